// ==== williams_pkg.sv ====
package williams_pkg;

    ////////////////////////////////////////
    // game selection

    typedef enum logic [2:0] {
        game_robotron   = 3'd0,
        game_joust      = 3'd1,
        game_stargate   = 3'd2,
        game_bubbles    = 3'd3,
        game_splat      = 3'd4,
        game_sinistar   = 3'd5,
        game_playball   = 3'd6,
        game_alienarena = 3'd7
    } game_id_t;

    // bridge register map
    localparam logic [31:0] addr_game_id  = 32'h8000_0000;
    localparam logic [31:0] addr_settings = 32'h9000_0000;

    ////////////////////////////////////////
    // controller

    // digital thresholds for analog sticks
    localparam logic [7:0] stick_low  = 8'd32;
    localparam logic [7:0] stick_high = 8'd224;

    // bit positions in the cont key word
    localparam logic [3:0] key_up     = 4'd0;
    localparam logic [3:0] key_down   = 4'd1;
    localparam logic [3:0] key_left   = 4'd2;
    localparam logic [3:0] key_right  = 4'd3;
    localparam logic [3:0] key_a      = 4'd4;
    localparam logic [3:0] key_b      = 4'd5;
    localparam logic [3:0] key_x      = 4'd6;
    localparam logic [3:0] key_y      = 4'd7;
    localparam logic [3:0] key_l1     = 4'd8;
    localparam logic [3:0] key_r1     = 4'd9;
    localparam logic [3:0] key_select = 4'd14;
    localparam logic [3:0] key_start  = 4'd15;

    // sinistar stick at rest
    localparam logic [3:0] pos_center = 4'd7;

    // soc joystick port, switch bits or sinistar position codes
    typedef union packed {
        logic [7:0] bits;
        struct packed {
            logic [3:0] x;
            logic [3:0] y;
        } pos;
    } joy_port_t;

    ////////////////////////////////////////
    // video

    // hblank points compare against pixel count / 2
    localparam logic [9:0]  hblank_on  = 10'd336;
    localparam logic [9:0]  hblank_off = 10'd40;
    localparam logic [10:0] vblank_on  = 11'd254;
    localparam logic [10:0] vblank_off = 11'd14;

    // dark green border around portrait games
    localparam logic [23:0] border_rgb = 24'h002000;

endpackage

// ==== bridge_config.sv ====
`timescale 1ns/1ps

module bridge_config (
    input  logic                   clk_74a,
    input  logic                   arst_n,
    input  logic [31:0]            bridge_addr,
    input  logic                   bridge_wr,
    input  logic [31:0]            bridge_wr_data,
    output williams_pkg::game_id_t game_id,
    output logic                   original_controls
);
    import williams_pkg::*;

    logic [31:0] settings;

    // exact address match, plain write strobe
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            game_id  <= game_robotron;
            settings <= 32'h0;
        end else if (bridge_wr) begin
            if (bridge_addr == addr_game_id) begin
                game_id <= game_id_t'(bridge_wr_data[2:0]);
            end
            if (bridge_addr == addr_settings) begin
                settings <= bridge_wr_data;
            end
        end
    end

    // only the control scheme bit is defined so far
    assign original_controls = settings[0];

    a_game_id_known: assert property (
        @(posedge clk_74a) disable iff (!arst_n) !$isunknown(game_id)
    );

endmodule

// ==== stick_quantizer.sv ====
`timescale 1ns/1ps

module stick_quantizer (
    input  logic [15:0] cont1_key,
    input  logic [31:0] cont1_joy,
    output logic        analog_present,
    output logic [7:0]  stick_dir,
    output logic [3:0]  pos_x,
    output logic [3:0]  pos_y
);
    import williams_pkg::*;

    logic [3:0] dig_x;
    logic [3:0] dig_y;
    logic [3:0] ana_x;
    logic [3:0] ana_y;

    // seven bands per axis, mirror flips the code order for y
    function automatic logic [3:0] quantize(input logic [7:0] v, input logic mirror);
        logic [3:0] code;
        if (v < stick_low) begin
            code = mirror ? 4'd8 : 4'd0;
        end else if (v < 8'd64) begin
            code = mirror ? 4'd9 : 4'd4;
        end else if (v < 8'd96) begin
            code = mirror ? 4'd11 : 4'd6;
        end else if (v > stick_high) begin
            code = mirror ? 4'd0 : 4'd8;
        end else if (v > 8'd192) begin
            code = mirror ? 4'd4 : 4'd9;
        end else if (v > 8'd160) begin
            code = mirror ? 4'd6 : 4'd11;
        end else begin
            code = pos_center;
        end
        return code;
    endfunction

    // a stick at exactly zero on both axes means no analog hardware
    assign analog_present = cont1_joy[15:0] != 16'h0;

    // pairs from the top: rx, ry, lx, ly; high above low in each pair
    for (genvar i = 0; i < 4; i++) begin : g_axis
        assign stick_dir[2*i+1] = cont1_joy[8*(i^1) +: 8] > stick_high;
        assign stick_dir[2*i]   = cont1_joy[8*(i^1) +: 8] < stick_low;
    end

    ////////////////////////////////////////
    // sinistar position

    assign dig_x = cont1_key[key_left] ? 4'd0 : cont1_key[key_right] ? 4'd8 : pos_center;
    assign dig_y = cont1_key[key_down] ? 4'd0 : cont1_key[key_up] ? 4'd8 : pos_center;

    assign ana_x = quantize(cont1_joy[7:0], 1'b0);
    assign ana_y = quantize(cont1_joy[15:8], 1'b1);

    // centered stick falls back to the d-pad
    assign pos_x = (analog_present && ana_x != pos_center) ? ana_x : dig_x;
    assign pos_y = (analog_present && ana_y != pos_center) ? ana_y : dig_y;

endmodule

// ==== control_mapper.sv ====
`timescale 1ns/1ps

module control_mapper (
    input  logic                    clk_74a,
    input  logic                    arst_n,
    input  williams_pkg::game_id_t  game_id,
    input  logic                    original_controls,
    input  logic [15:0]             cont1_key,
    input  logic [15:0]             cont2_key,
    input  logic [31:0]             cont1_joy,
    input  logic                    sg_state,
    output williams_pkg::joy_port_t ja,
    output williams_pkg::joy_port_t jb,
    output logic [2:0]              btn,
    output logic [7:0]              sw,
    output logic                    blitter_sc2,
    output logic                    sinistar,
    output logic                    landscape
);
    import williams_pkg::*;

    logic       analog_present;
    logic [7:0] stick_dir;
    logic [3:0] pos_x;
    logic [3:0] pos_y;

    joy_port_t  ja_act;
    joy_port_t  jb_act;
    logic [2:0] btn_d;
    logic       sc2_d;
    logic       sinistar_d;
    logic       landscape_d;

    logic       coin1;
    logic       coin2;
    logic       start1;
    logic       start2;
    logic       sg_t;
    logic       sg_u;

    // robotron and splat layout
    function automatic logic [7:0] full_pad(input logic [15:0] k);
        return {k[key_a], k[key_y], k[key_b], k[key_x],
                k[key_right], k[key_left], k[key_down], k[key_up]};
    endfunction

    function automatic logic [7:0] joust_pad(input logic [15:0] k);
        return {5'b00000, k[key_a], k[key_right], k[key_left]};
    endfunction

    function automatic logic [7:0] alien_pad(input logic [15:0] k);
        return {2'b00, k[key_b], k[key_a],
                k[key_right], k[key_left], k[key_down], k[key_up]};
    endfunction

    stick_quantizer u_stick (
        .cont1_key      (cont1_key),
        .cont1_joy      (cont1_joy),
        .analog_present (analog_present),
        .stick_dir      (stick_dir),
        .pos_x          (pos_x),
        .pos_y          (pos_y)
    );

    assign coin1  = cont1_key[key_select];
    assign coin2  = cont2_key[key_select];
    assign start1 = cont1_key[key_start];
    assign start2 = cont2_key[key_start];

    // stargate thrust and reverse, or follow the ship's facing
    assign sg_t = original_controls ? cont1_key[key_l1]
                : (sg_state ? cont1_key[key_right] : cont1_key[key_left]);
    assign sg_u = original_controls ? cont1_key[key_r1]
                : (sg_state ? cont1_key[key_left] : cont1_key[key_right]);

    ////////////////////////////////////////
    // per-game mapping, active high here

    always_comb begin
        btn_d       = 3'b000;
        ja_act.bits = 8'h00;
        jb_act.bits = 8'h00;
        sc2_d       = 1'b0;
        sinistar_d  = 1'b0;
        landscape_d = 1'b1;
        case (game_id)
            game_robotron: begin
                btn_d       = {start1, start2, coin1 | coin2};
                ja_act.bits = full_pad(cont1_key) | (analog_present ? stick_dir : 8'h00);
                jb_act      = ja_act;
            end
            game_joust: begin
                btn_d       = {start2, start1, coin1 | coin2};
                ja_act.bits = joust_pad(cont1_key);
                jb_act.bits = joust_pad(cont2_key);
            end
            game_splat: begin
                sc2_d       = 1'b1;
                btn_d       = {start1, start2, coin1 | coin2};
                ja_act.bits = full_pad(cont1_key);
                jb_act.bits = full_pad(cont2_key);
            end
            game_bubbles: begin
                btn_d       = {start2, start1, coin1 | coin2};
                ja_act.bits = {4'b0000, cont1_key[key_right], cont1_key[key_left],
                               cont1_key[key_down], cont1_key[key_up]};
                jb_act      = ja_act;
            end
            game_stargate: begin
                btn_d       = {start2, start1, coin1};
                ja_act.bits = {cont1_key[key_b], cont1_key[key_up], cont1_key[key_down], sg_t,
                               cont1_key[key_y], cont1_key[key_x], sg_u, cont1_key[key_a]};
                jb_act      = ja_act;
            end
            game_alienarena: begin
                btn_d       = {start1, start2, coin1};
                ja_act.bits = alien_pad(cont1_key);
                jb_act.bits = alien_pad(cont2_key);
            end
            game_sinistar: begin
                sinistar_d   = 1'b1;
                landscape_d  = 1'b0;
                btn_d        = {start1, start2, coin1};
                ja_act.pos.x = pos_x;
                ja_act.pos.y = pos_y;
                jb_act       = ja_act;
            end
            game_playball: begin
                landscape_d = 1'b0;
                btn_d       = {2'b00, coin1};
                ja_act.bits = {4'b0000, start2, cont1_key[key_right],
                               cont1_key[key_left], start1};
                jb_act      = ja_act;
            end
        endcase
    end

    // soc switch inputs are active low
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            ja.bits     <= 8'hff;
            jb.bits     <= 8'hff;
            btn         <= 3'b000;
            sw          <= 8'h00;
            blitter_sc2 <= 1'b0;
            sinistar    <= 1'b0;
            landscape   <= 1'b1;
        end else begin
            ja.bits     <= ~ja_act.bits;
            jb.bits     <= ~jb_act.bits;
            btn         <= btn_d;
            // advance is coin plus l1, auto-up is r1
            sw          <= {6'b000000, coin1 & cont1_key[key_l1], cont1_key[key_r1]};
            blitter_sc2 <= sc2_d;
            sinistar    <= sinistar_d;
            landscape   <= landscape_d;
        end
    end

endmodule

// ==== video_timing.sv ====
`timescale 1ns/1ps

module video_timing (
    input  logic clk_74a,
    input  logic arst_n,
    input  logic core_hs,
    input  logic core_vs,
    output logic hblank,
    output logic vblank
);
    import williams_pkg::*;

    logic [10:0] pcnt;
    logic [10:0] lcnt;
    logic        hs_prev;
    logic        vs_at_hs;
    logic        hs_rise;

    assign hs_rise = core_hs && !hs_prev;

    ////////////////////////////////////////
    // counters

    // vs is only looked at on hs edges
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            pcnt     <= 11'd0;
            lcnt     <= 11'd0;
            hs_prev  <= 1'b0;
            vs_at_hs <= 1'b0;
        end else begin
            hs_prev <= core_hs;
            if (hs_rise) begin
                pcnt     <= 11'd0;
                vs_at_hs <= core_vs;
                if (core_vs && !vs_at_hs) begin
                    lcnt <= 11'd0;
                end else if (!(&lcnt)) begin
                    lcnt <= lcnt + 11'd1;
                end
            end else if (!(&pcnt)) begin
                pcnt <= pcnt + 11'd1;
            end
        end
    end

    ////////////////////////////////////////
    // blank flags

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            hblank <= 1'b0;
            vblank <= 1'b0;
        end else begin
            if (pcnt[10:1] == hblank_on) begin
                hblank <= 1'b1;
            end else if (pcnt[10:1] == hblank_off) begin
                hblank <= 1'b0;
            end
            if (lcnt == vblank_on) begin
                vblank <= 1'b1;
            end else if (lcnt == vblank_off) begin
                vblank <= 1'b0;
            end
        end
    end

    a_flags_known: assert property (
        @(posedge clk_74a) disable iff (!arst_n) !$isunknown({hblank, vblank})
    );

endmodule

// ==== scaler_output.sv ====
`timescale 1ns/1ps

module scaler_output (
    input  logic        clk_74a,
    input  logic        arst_n,
    input  logic        hblank,
    input  logic        vblank,
    input  logic        landscape,
    input  logic [2:0]  core_r,
    input  logic [2:0]  core_g,
    input  logic [1:0]  core_b,
    input  logic        core_hs,
    input  logic        core_vs,
    input  logic [7:0]  core_audio,
    input  logic [15:0] core_speech,
    output logic [23:0] video_rgb,
    output logic        video_de,
    output logic        video_hs,
    output logic        video_vs,
    output logic [14:0] audio_out
);
    import williams_pkg::*;

    logic        hs_prev;
    logic        vs_prev;
    logic [16:0] audio_sum;

    // fm in the upper byte, speech added at full width
    assign audio_sum = {1'b0, core_audio, 8'h00} + {1'b0, core_speech};

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            video_rgb <= 24'h0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
            audio_out <= 15'h0;
        end else begin
            if (!(hblank || vblank)) begin
                video_de  <= 1'b1;
                // stretch 3-3-2 bits to 8 per channel
                video_rgb <= {core_r, core_r, core_r[2:1],
                              core_g, core_g, core_g[2:1],
                              {4{core_b}}};
            end else begin
                video_de  <= 1'b0;
                video_rgb <= landscape ? 24'h0 : border_rgb;
            end
            // one-cycle pulses on the sync edges
            video_hs  <= core_hs && !hs_prev;
            video_vs  <= core_vs && !vs_prev;
            hs_prev   <= core_hs;
            vs_prev   <= core_vs;
            audio_out <= audio_sum[16:2];
        end
    end

    a_hs_single: assert property (
        @(posedge clk_74a) disable iff (!arst_n) video_hs |=> !video_hs
    );

endmodule

// ==== williams_io_top.sv ====
`timescale 1ns/1ps

module williams_io_top (
    input  logic                    clk_74a,
    input  logic                    arst_n,
    // bridge
    input  logic [31:0]             bridge_addr,
    input  logic                    bridge_wr,
    input  logic [31:0]             bridge_wr_data,
    // controllers
    input  logic [15:0]             cont1_key,
    input  logic [15:0]             cont2_key,
    input  logic [31:0]             cont1_joy,
    // from the game soc
    input  logic [2:0]              core_r,
    input  logic [2:0]              core_g,
    input  logic [1:0]              core_b,
    input  logic                    core_hs,
    input  logic                    core_vs,
    input  logic [7:0]              core_audio,
    input  logic [15:0]             core_speech,
    input  logic                    sg_state,
    // to the game soc
    output williams_pkg::joy_port_t ja,
    output williams_pkg::joy_port_t jb,
    output logic [2:0]              btn,
    output logic [7:0]              sw,
    output logic                    blitter_sc2,
    output logic                    sinistar,
    output logic                    landscape,
    // to the scaler
    output logic [23:0]             video_rgb,
    output logic                    video_de,
    output logic                    video_hs,
    output logic                    video_vs,
    output logic [14:0]             audio_out
);
    import williams_pkg::*;

    game_id_t game_id;
    logic     original_controls;
    logic     hblank;
    logic     vblank;

    bridge_config u_config (
        .clk_74a           (clk_74a),
        .arst_n            (arst_n),
        .bridge_addr       (bridge_addr),
        .bridge_wr         (bridge_wr),
        .bridge_wr_data    (bridge_wr_data),
        .game_id           (game_id),
        .original_controls (original_controls)
    );

    control_mapper u_mapper (
        .clk_74a           (clk_74a),
        .arst_n            (arst_n),
        .game_id           (game_id),
        .original_controls (original_controls),
        .cont1_key         (cont1_key),
        .cont2_key         (cont2_key),
        .cont1_joy         (cont1_joy),
        .sg_state          (sg_state),
        .ja                (ja),
        .jb                (jb),
        .btn               (btn),
        .sw                (sw),
        .blitter_sc2       (blitter_sc2),
        .sinistar          (sinistar),
        .landscape         (landscape)
    );

    video_timing u_timing (
        .clk_74a (clk_74a),
        .arst_n  (arst_n),
        .core_hs (core_hs),
        .core_vs (core_vs),
        .hblank  (hblank),
        .vblank  (vblank)
    );

    // landscape also picks the border color
    scaler_output u_scaler (
        .clk_74a     (clk_74a),
        .arst_n      (arst_n),
        .hblank      (hblank),
        .vblank      (vblank),
        .landscape   (landscape),
        .core_r      (core_r),
        .core_g      (core_g),
        .core_b      (core_b),
        .core_hs     (core_hs),
        .core_vs     (core_vs),
        .core_audio  (core_audio),
        .core_speech (core_speech),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .audio_out   (audio_out)
    );

endmodule

// ==== tb_williams_io_cases.svh ====
`ifndef TB_WILLIAMS_IO_CASES_SVH
`define TB_WILLIAMS_IO_CASES_SVH

typedef struct packed {
    game_id_t    game;
    logic [31:0] settings;
    logic [15:0] key1;
    logic [15:0] key2;
    logic [31:0] joy;
    logic        sg;
    logic [7:0]  ja;
    logic [7:0]  jb;
    logic [2:0]  btn;
    logic [7:0]  sw;
    logic        sc2;
    logic        sin;
    logic        land;
} map_case_t;

localparam int num_cases = 21;

// game, settings, key1, key2, joy, sg, then expected ja, jb, btn, sw, sc2, sinistar, landscape
map_case_t cases [num_cases] = '{
    '{game_robotron,   32'h0, 16'h8011, 16'h4000, 32'h0000_0000, 1'b0,
      8'h7e, 8'h7e, 3'b101, 8'h00, 1'b0, 1'b0, 1'b1},
    '{game_robotron,   32'h0, 16'h0001, 16'h0000, 32'h80f0_8010, 1'b0,
      8'h7a, 8'h7a, 3'b000, 8'h00, 1'b0, 1'b0, 1'b1},
    '{game_robotron,   32'h0, 16'h4300, 16'h0000, 32'h0000_0000, 1'b0,
      8'hff, 8'hff, 3'b001, 8'h03, 1'b0, 1'b0, 1'b1},
    '{game_joust,      32'h0, 16'h0018, 16'h8004, 32'h0000_0000, 1'b0,
      8'hf9, 8'hfe, 3'b100, 8'h00, 1'b0, 1'b0, 1'b1},
    '{game_splat,      32'h0, 16'h8082, 16'h0048, 32'h0000_0000, 1'b0,
      8'hbd, 8'he7, 3'b100, 8'h00, 1'b1, 1'b0, 1'b1},
    '{game_bubbles,    32'h0, 16'h8009, 16'h4000, 32'h0000_0000, 1'b0,
      8'hf6, 8'hf6, 3'b011, 8'h00, 1'b0, 1'b0, 1'b1},
    // stargate, original controls then ship facing
    '{game_stargate,   32'h1, 16'h0130, 16'h0000, 32'h0000_0000, 1'b0,
      8'h6e, 8'h6e, 3'b000, 8'h00, 1'b0, 1'b0, 1'b1},
    '{game_stargate,   32'h1, 16'h0201, 16'h0000, 32'h0000_0000, 1'b1,
      8'hbd, 8'hbd, 3'b000, 8'h01, 1'b0, 1'b0, 1'b1},
    '{game_stargate,   32'h0, 16'h0044, 16'h0000, 32'h0000_0000, 1'b0,
      8'heb, 8'heb, 3'b000, 8'h00, 1'b0, 1'b0, 1'b1},
    '{game_stargate,   32'h0, 16'h4084, 16'h0000, 32'h0000_0000, 1'b1,
      8'hf5, 8'hf5, 3'b001, 8'h00, 1'b0, 1'b0, 1'b1},
    '{game_alienarena, 32'h0, 16'h8022, 16'h4011, 32'h0000_0000, 1'b0,
      8'hdd, 8'hee, 3'b100, 8'h00, 1'b0, 1'b0, 1'b1},
    '{game_playball,   32'h0, 16'hc008, 16'h8000, 32'h0000_0000, 1'b0,
      8'hf2, 8'hf2, 3'b001, 8'h00, 1'b0, 1'b0, 1'b0},
    // sinistar d-pad, then one analog band per row on both axes
    '{game_sinistar,   32'h0, 16'hc000, 16'h0000, 32'h0000_0000, 1'b0,
      8'h88, 8'h88, 3'b101, 8'h00, 1'b0, 1'b1, 1'b0},
    '{game_sinistar,   32'h0, 16'h0005, 16'h0000, 32'h0000_0000, 1'b0,
      8'hf7, 8'hf7, 3'b000, 8'h00, 1'b0, 1'b1, 1'b0},
    '{game_sinistar,   32'h0, 16'h0000, 16'h0000, 32'h0000_1010, 1'b0,
      8'hf7, 8'hf7, 3'b000, 8'h00, 1'b0, 1'b1, 1'b0},
    '{game_sinistar,   32'h0, 16'h0000, 16'h0000, 32'h0000_3030, 1'b0,
      8'hb6, 8'hb6, 3'b000, 8'h00, 1'b0, 1'b1, 1'b0},
    '{game_sinistar,   32'h0, 16'h0000, 16'h0000, 32'h0000_5050, 1'b0,
      8'h94, 8'h94, 3'b000, 8'h00, 1'b0, 1'b1, 1'b0},
    '{game_sinistar,   32'h0, 16'h0000, 16'h0000, 32'h0000_f0f0, 1'b0,
      8'h7f, 8'h7f, 3'b000, 8'h00, 1'b0, 1'b1, 1'b0},
    '{game_sinistar,   32'h0, 16'h0000, 16'h0000, 32'h0000_d0d0, 1'b0,
      8'h6b, 8'h6b, 3'b000, 8'h00, 1'b0, 1'b1, 1'b0},
    '{game_sinistar,   32'h0, 16'h0000, 16'h0000, 32'h0000_b0b0, 1'b0,
      8'h49, 8'h49, 3'b000, 8'h00, 1'b0, 1'b1, 1'b0},
    // centered stick, d-pad wins
    '{game_sinistar,   32'h0, 16'h0009, 16'h0000, 32'h0000_8080, 1'b0,
      8'h77, 8'h77, 3'b000, 8'h00, 1'b0, 1'b1, 1'b0}
};

`endif

// ==== tb_williams_io.sv ====
`timescale 1ns/1ps

module tb_williams_io;
    import williams_pkg::*;

    localparam int line_len = 800;
    localparam int hs_width = 64;

    logic        clk_74a;
    logic        arst_n;
    logic [31:0] bridge_addr;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic [15:0] cont1_key;
    logic [15:0] cont2_key;
    logic [31:0] cont1_joy;
    logic [2:0]  core_r;
    logic [2:0]  core_g;
    logic [1:0]  core_b;
    logic        core_hs;
    logic        core_vs;
    logic [7:0]  core_audio;
    logic [15:0] core_speech;
    logic        sg_state;
    joy_port_t   ja;
    joy_port_t   jb;
    logic [2:0]  btn;
    logic [7:0]  sw;
    logic        blitter_sc2;
    logic        sinistar;
    logic        landscape;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;
    logic [14:0] audio_out;

    integer seed;
    int     de_seen;
    int     blank_seen;
    int     idx;

    `include "tb_williams_io_cases.svh"

    williams_io_top UUT (.*);

    always #10 clk_74a = ~clk_74a;

    ////////////////////////////////////////
    // checks

    task abort_run;
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task check_port(input string name, input joy_port_t expected, input joy_port_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %02h actual %02h", name, expected.bits,
                     actual.bits);
            abort_run();
        end
    endtask

    task check_bits8(input string name, input logic [7:0] expected, input logic [7:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %02h actual %02h", name, expected, actual);
            abort_run();
        end
    endtask

    task check_btn(input string name, input logic [2:0] expected, input logic [2:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %03b actual %03b", name, expected, actual);
            abort_run();
        end
    endtask

    task check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task check_audio(input string name, input logic [14:0] expected, input logic [14:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %04h actual %04h", name, expected, actual);
            abort_run();
        end
    endtask

    task check_rgb(input string name, input logic [23:0] expected, input logic [23:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %06h actual %06h", name, expected, actual);
            abort_run();
        end
    endtask

    // 3-3-2 color stretched to 8 bits per channel
    function automatic logic [23:0] expand_rgb(input logic [2:0] r, input logic [2:0] g,
                                               input logic [1:0] b);
        return {r, r, r[2:1], g, g, g[2:1], b, b, b, b};
    endfunction

    ////////////////////////////////////////
    // stimulus

    task bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_74a);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr      = 1'b0;
    endtask

    task compare_mapping(input map_case_t c, input string name);
        check_port({name, " ja"}, joy_port_t'(c.ja), ja);
        check_port({name, " jb"}, joy_port_t'(c.jb), jb);
        check_btn({name, " btn"}, c.btn, btn);
        check_bits8({name, " sw"}, c.sw, sw);
        check_flag({name, " blitter_sc2"}, c.sc2, blitter_sc2);
        check_flag({name, " sinistar"}, c.sin, sinistar);
        check_flag({name, " landscape"}, c.land, landscape);
    endtask

    task apply_case(input int n);
        map_case_t c;
        c = cases[n];
        @(negedge clk_74a);
        cont1_key = c.key1;
        cont2_key = c.key2;
        cont1_joy = c.joy;
        sg_state  = c.sg;
        bridge_write(addr_game_id, {29'h0, c.game});
        bridge_write(addr_settings, c.settings);
        // one more edge for the mapper registers
        @(negedge clk_74a);
        compare_mapping(c, $sformatf("case %0d", n));
    endtask

    task inspect_pixel(input logic [23:0] color, input logic [23:0] blank_rgb);
        if (video_de) begin
            de_seen++;
            check_rgb("video active", color, video_rgb);
        end else begin
            blank_seen++;
            check_rgb("video blank", blank_rgb, video_rgb);
        end
    endtask

    // one scan line, hs rises at its start
    task run_line(input logic vs_on, input logic [23:0] color, input logic [23:0] blank_rgb);
        int   waited;
        int   c;
        logic seen;
        @(negedge clk_74a);
        inspect_pixel(color, blank_rgb);
        core_hs = 1'b1;
        core_vs = vs_on;
        waited  = 0;
        seen    = 1'b0;
        while (!seen && waited < 3) begin
            @(negedge clk_74a);
            inspect_pixel(color, blank_rgb);
            waited++;
            seen = video_hs;
        end
        if (!seen) begin
            $display("timeout: no video_hs pulse within 3 cycles of a core_hs rise");
            abort_run();
        end
        // vs rose together with hs on a frame line
        check_flag("video_vs pulse", vs_on, video_vs);
        for (c = waited + 1; c < line_len; c++) begin
            @(negedge clk_74a);
            inspect_pixel(color, blank_rgb);
            check_flag("video_hs single pulse", 1'b0, video_hs);
            check_flag("video_vs single pulse", 1'b0, video_vs);
            if (c == hs_width) begin
                core_hs = 1'b0;
                core_vs = 1'b0;
            end
        end
    endtask

    task run_video(input game_id_t game, input logic [23:0] blank_rgb);
        logic [31:0] rnd;
        int          line;
        bridge_write(addr_game_id, {29'h0, game});
        rnd = $random(seed);
        @(negedge clk_74a);
        core_r = rnd[2:0];
        core_g = rnd[5:3];
        core_b = rnd[7:6];
        // landscape reaches the scaler two edges after the game register
        repeat (3) @(negedge clk_74a);
        de_seen    = 0;
        blank_seen = 0;
        for (line = 0; line < 4; line++) begin
            run_line(line == 1, expand_rgb(core_r, core_g, core_b), blank_rgb);
        end
        if (de_seen == 0 || blank_seen == 0) begin
            $display("video never showed both active and blanked pixels");
            abort_run();
        end
    endtask

    task run_audio;
        int expected;
        int i;
        for (i = 0; i < 16; i++) begin
            @(negedge clk_74a);
            if (i == 0) begin
                core_audio  = 8'hff;
                core_speech = 16'hffff;
            end else begin
                core_audio  = $random(seed);
                core_speech = $random(seed);
            end
            @(negedge clk_74a);
            // fm is worth 256 speech steps, the two lowest bits drop off
            expected = (core_audio * 256 + core_speech) / 4;
            check_audio($sformatf("audio pair %0d", i), expected[14:0], audio_out);
        end
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        seed           = 32'h2cec;
        clk_74a        = 1'b0;
        arst_n         = 1'b0;
        bridge_addr    = 32'h0;
        bridge_wr      = 1'b0;
        bridge_wr_data = 32'h0;
        cont1_key      = 16'h0;
        cont2_key      = 16'h0;
        cont1_joy      = 32'h0;
        core_r         = 3'h0;
        core_g         = 3'h0;
        core_b         = 2'h0;
        core_hs        = 1'b0;
        core_vs        = 1'b0;
        core_audio     = 8'h0;
        core_speech    = 16'h0;
        sg_state       = 1'b0;

        repeat (8) @(negedge clk_74a);
        arst_n = 1'b1;
        @(negedge clk_74a);
        check_port("reset ja", joy_port_t'(8'hff), ja);
        check_port("reset jb", joy_port_t'(8'hff), jb);
        check_btn("reset btn", 3'b000, btn);
        check_flag("reset landscape", 1'b1, landscape);

        for (idx = 0; idx < num_cases; idx++) begin
            apply_case(idx);
        end

        // writes elsewhere in the map must not touch the game registers
        bridge_write(32'h8000_0004, 32'h1);
        bridge_write(32'ha000_0000, 32'h3);
        bridge_write(32'h0000_0000, 32'h1);
        @(negedge clk_74a);
        compare_mapping(cases[num_cases-1], "stray write");

        run_video(game_robotron, 24'h000000);
        run_video(game_sinistar, 24'h002000);
        run_audio();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== williams_io_top.f ====
+incdir+.
williams_pkg.sv
bridge_config.sv
stick_quantizer.sv
control_mapper.sv
video_timing.sv
scaler_output.sv
williams_io_top.sv
tb_williams_io.sv

// ==== Bender.yml ====
package:
  name: williams_io

sources:
  - files:
      - williams_pkg.sv
      - bridge_config.sv
      - stick_quantizer.sv
      - control_mapper.sv
      - video_timing.sv
      - scaler_output.sv
      - williams_io_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_williams_io.sv
